// ==== all.f ====
hdl/usb_dfu_pkg.sv
hdl/setup_capture.sv
hdl/ctrl_xfer_fsm.sv
hdl/dfu_request_decoder.sv
hdl/descriptor_rom.sv
hdl/dfu_detach_timer.sv
hdl/usb_dfu_rt_top.sv
tb/dfu_checker.sv
tb/tb_usb_dfu_rt.sv

// ==== hdl/ctrl_xfer_fsm.sv ====
`timescale 1ns/1ps

module ctrl_xfer_fsm
  import usb_dfu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  out_ep_in_t out_ep,
  input  in_ep_in_t  in_ep_i,
  input  setup_pkt_t setup,
  input  req_info_t  req,
  output logic       setup_stage_end,
  output logic       status_stage_end,
  output logic [7:0] rom_addr,
  output logic       out_ep_req,
  output logic       out_ep_data_get,
  output in_ep_out_t in_ctrl
);

  ctrl_state_t state, state_next;

  logic        avail_q;
  logic        load_q;     // req is valid, counters load this cycle
  logic        empty_q;
  logic        done_q;
  logic        zlp;        // zero length data packet
  logic [15:0] rom_cnt;
  logic [15:0] data_cnt;

  assign out_ep_req      = out_ep.data_avail;
  assign out_ep_data_get = out_ep.data_avail;

  wire pkt_start       = out_ep.data_avail && !avail_q;
  wire pkt_end         = !out_ep.data_avail && avail_q;
  wire setup_pkt_start = pkt_start && out_ep.setup;

  wire has_data_stage = |setup.w_length;
  wire in_stage       = has_data_stage && setup.bm_request_type[7];
  wire out_stage      = has_data_stage && !setup.bm_request_type[7];

  wire bytes_left = (rom_cnt != 16'd0) && (data_cnt != 16'd0);
  wire sending    = (state == data_in) && !load_q;
  wire all_sent   = sending && !bytes_left;
  wire stall_now  = load_q && req.stall;
  wire in_xfer    = in_ctrl.data_put && in_ep_i.grant;
  wire out_xfer   = (state == data_out) && out_ep.grant && out_ep.data_avail &&
                    !out_ep.setup && (data_cnt != 16'd0);

  assign in_ctrl.req       = sending && bytes_left;
  assign in_ctrl.data_put  = sending && bytes_left && in_ep_i.data_free;
  assign in_ctrl.data      = 8'h00;  // filled in by the rom at top level
  assign in_ctrl.data_done = done_q || zlp;
  assign in_ctrl.stall     = stall_now;

  //////////////////////////////////////////////////////////////////////
  // stage sequencer
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    state_next       = state;
    setup_stage_end  = 1'b0;
    status_stage_end = 1'b0;
    zlp              = 1'b0;
    if (stall_now) begin
      state_next       = idle;  // stall aborts the transfer
      status_stage_end = 1'b1;
    end else begin
      case (state)
        idle:       if (setup_pkt_start) state_next = setup_in;
        setup_in:   if (pkt_end) state_next = setup_done;
        setup_done: begin
          setup_stage_end = 1'b1;
          if (in_stage) begin
            state_next = data_in;
          end else if (out_stage) begin
            state_next = data_out;
          end else begin
            state_next = status_in;
            zlp        = 1'b1;
          end
        end
        data_in:    if (in_ep_i.acked && all_sent) state_next = status_out;
        data_out: begin
          if (!load_q && data_cnt == 16'd0) begin
            state_next = status_in;
            zlp        = 1'b1;
          end
        end
        status_in, status_out: begin
          if ((state == status_in) ? in_ep_i.acked : out_ep.acked) begin
            state_next       = idle;
            status_stage_end = 1'b1;
          end
        end
        default:    state_next = idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= idle;
      avail_q <= 1'b0;
      load_q  <= 1'b0;
      empty_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      state   <= state_next;
      avail_q <= out_ep.data_avail;
      load_q  <= setup_stage_end;
      empty_q <= all_sent;
      done_q  <= all_sent && !empty_q;  // one cycle after first empty cycle
    end
  end

  //////////////////////////////////////////////////////////////////////
  // data stage counters
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      rom_addr <= '0;
      rom_cnt  <= '0;
      data_cnt <= '0;
    end else begin
      if (load_q) begin
        rom_addr <= req.start_addr;
        rom_cnt  <= req.rom_len;
        data_cnt <= setup.w_length;
      end else if (in_xfer) begin
        rom_addr <= rom_addr + 8'd1;
        rom_cnt  <= rom_cnt - 16'd1;
        data_cnt <= data_cnt - 16'd1;
      end else if (out_xfer) begin
        data_cnt <= data_cnt - 16'd1;
      end
      if (status_stage_end) begin
        rom_addr <= '0;
        rom_cnt  <= '0;
      end
    end
  end

endmodule

// ==== hdl/descriptor_rom.sv ====
`timescale 1ns/1ps

module descriptor_rom
  import usb_dfu_pkg::*;
(
  input  rom_src_t   src,
  input  logic [7:0] rom_addr,
  input  logic [7:0] dfu_state,
  input  logic [7:0] dfu_status,
  output logic [7:0] data
);

  logic [7:0] desc [45];
  logic [7:0] desc_byte;
  logic [7:0] status_byte;

  assign desc = '{
    // device descriptor
    8'd18, DESC_DEVICE, 8'h00, 8'h01,   // bcdUSB 1.00
    8'h00, 8'h00, 8'h00, MAX_PACKET_SIZE,
    BOARD_VID[7:0], BOARD_VID[15:8],
    BOARD_PID[7:0], BOARD_PID[15:8],
    8'h00, 8'h00,                       // bcdDevice
    8'h00, 8'h00, 8'h00,                // no string indices
    8'd1,                               // one configuration
    // configuration
    8'd9, DESC_CONFIG, CONF_TOTAL_LEN[7:0], CONF_TOTAL_LEN[15:8],
    8'd1, 8'd1, 8'd0, 8'hc0, 8'd50,     // self powered, 100 mA
    // interface, dfu runtime class
    8'd9, 8'h04, 8'd0, 8'd0, 8'd0, 8'hfe, 8'h01, 8'h01, 8'h00,
    // dfu functional descriptor
    8'd9, 8'h21, 8'h0f,
    DFU_DETACH_TIMEOUT[7:0], DFU_DETACH_TIMEOUT[15:8],
    TRANSFER_SIZE[7:0], TRANSFER_SIZE[15:8],
    8'h10, 8'h01                        // bcdDFUVersion 1.10
  };

  assign desc_byte = (rom_addr < 8'd45) ? desc[rom_addr[5:0]] : 8'h00;

  // getstatus block, poll timeout fixed at 1 ms
  always_comb begin
    case (rom_addr)
      8'd0:    status_byte = dfu_status;
      8'd1:    status_byte = 8'd1;
      8'd4:    status_byte = dfu_state;
      default: status_byte = 8'h00;
    endcase
  end

  assign data = (src == src_dfu_status) ? status_byte : desc_byte;

endmodule

// ==== hdl/dfu_detach_timer.sv ====
`timescale 1ns/1ps

module dfu_detach_timer
  import usb_dfu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       usb_reset,
  input  logic [7:0] dfu_state,
  output logic       dfu_detach
);

  logic [15:0] presc;    // cycles within the current ms
  logic [15:0] ms_left;

  wire detaching = (dfu_state == DFU_STATE_APP_DETACH);
  wire ms_tick   = detaching && (presc == 16'(CYCLES_PER_MS - 1));

  always_ff @(posedge clk) begin
    if (reset || !detaching) begin
      presc   <= '0;
      ms_left <= 16'(SIM_DETACH_MS);
    end else if (ms_tick) begin
      presc   <= '0;
      ms_left <= ms_left - 16'd1;
    end else begin
      presc <= presc + 16'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      dfu_detach <= 1'b0;
    end else if (usb_reset && dfu_state != DFU_STATE_APP_IDLE) begin
      dfu_detach <= 1'b1;
    end else if (ms_tick && ms_left == 16'd1) begin
      dfu_detach <= 1'b1;  // last ms expired
    end
  end

endmodule

// ==== hdl/dfu_request_decoder.sv ====
`timescale 1ns/1ps

module dfu_request_decoder
  import usb_dfu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       usb_reset,
  input  setup_pkt_t setup,
  input  logic       setup_stage_end,
  input  logic       status_stage_end,
  output req_info_t  req,
  output logic [6:0] dev_addr,
  output logic [7:0] dfu_state,
  output logic [7:0] dfu_status
);

  req_info_t  dec;
  logic       go_detach;
  logic       go_idle;
  logic       clr_status;
  logic       set_addr;
  logic       addr_pending;
  logic [6:0] new_addr;

  wire [8:0] req_key = {setup.bm_request_type[5], setup.b_request};

  always_comb begin
    dec        = '0;
    dec.src    = src_desc;
    go_detach  = 1'b0;
    go_idle    = 1'b0;
    clr_status = 1'b0;
    set_addr   = 1'b0;
    if (!setup.bm_request_type[6]) begin  // vendor requests fall through
      case (req_key)
        REQ_GET_DESCRIPTOR: begin
          case (setup.w_value[15:8])
            DESC_DEVICE: begin
              dec.start_addr = DEV_DESC_ADDR;
              dec.rom_len    = DEV_DESC_LEN;
            end
            DESC_CONFIG: begin
              dec.start_addr = CONF_DESC_ADDR;
              dec.rom_len    = CONF_TOTAL_LEN;
            end
            DESC_QUALIFIER: dec.stall = 1'b1;  // full speed only
            default: ;                         // strings get zero length
          endcase
        end
        REQ_SET_ADDRESS:   set_addr = 1'b1;
        REQ_DFU_DETACH:    go_detach = 1'b1;
        REQ_DFU_GETSTATUS: begin
          dec.src     = src_dfu_status;
          dec.rom_len = DFU_STATUS_LEN;
        end
        REQ_DFU_CLRSTATUS: begin
          go_idle    = 1'b1;
          clr_status = 1'b1;
        end
        REQ_DFU_GETSTATE: begin
          dec.src        = src_dfu_status;
          dec.start_addr = DFU_BSTATE_ADDR;
          dec.rom_len    = 16'd1;
        end
        REQ_DFU_ABORT:     go_idle = 1'b1;
        default: ;  // set config and interface need no data either
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      req        <= '0;
      dfu_state  <= DFU_STATE_APP_IDLE;
      dfu_status <= DFU_STATUS_OK;
    end else if (setup_stage_end) begin
      req <= dec;
      if (go_detach) begin
        dfu_state <= DFU_STATE_APP_DETACH;
      end else if (go_idle) begin
        dfu_state <= DFU_STATE_APP_IDLE;
      end
      if (clr_status) dfu_status <= DFU_STATUS_OK;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // address takes effect once the status stage is done
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset || usb_reset) begin
      dev_addr     <= '0;
      addr_pending <= 1'b0;
    end else if (setup_stage_end && set_addr) begin
      addr_pending <= 1'b1;
    end else if (status_stage_end && addr_pending) begin
      dev_addr     <= new_addr;
      addr_pending <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (setup_stage_end && set_addr) new_addr <= setup.w_value[6:0];
  end

endmodule

// ==== hdl/setup_capture.sv ====
`timescale 1ns/1ps

module setup_capture
  import usb_dfu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       usb_reset,
  input  out_ep_in_t out_ep,
  input  logic       status_stage_end,
  output setup_pkt_t setup
);

  logic       data_valid;  // byte on out_ep.data this cycle
  logic [2:0] ptr;

  always_ff @(posedge clk) begin
    if (reset) begin
      data_valid <= 1'b0;
    end else begin
      data_valid <= out_ep.data_avail && out_ep.grant;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || usb_reset || status_stage_end) begin
      ptr <= '0;
    end else if (out_ep.setup && data_valid) begin
      ptr <= ptr + 3'd1;
    end
  end

  // little endian fields, byte 0 first
  always_ff @(posedge clk) begin
    if (out_ep.setup && data_valid) begin
      case (ptr)
        3'd0: setup.bm_request_type <= out_ep.data;
        3'd1: setup.b_request       <= out_ep.data;
        3'd2: setup.w_value[7:0]    <= out_ep.data;
        3'd3: setup.w_value[15:8]   <= out_ep.data;
        3'd4: setup.w_index[7:0]    <= out_ep.data;
        3'd5: setup.w_index[15:8]   <= out_ep.data;
        3'd6: setup.w_length[7:0]   <= out_ep.data;
        default: setup.w_length[15:8] <= out_ep.data;
      endcase
    end
  end

endmodule

// ==== hdl/usb_dfu_pkg.sv ====
package usb_dfu_pkg;

  //////////////////////////////////////////////////////////////////////
  // control transfer types
  //////////////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    idle, setup_in, setup_done, data_in, data_out, status_in, status_out
  } ctrl_state_t;

  typedef enum logic {
    src_desc,       // device and configuration descriptors
    src_dfu_status  // live DFU status block
  } rom_src_t;

  typedef struct packed {
    logic [7:0]  bm_request_type;
    logic [7:0]  b_request;
    logic [15:0] w_value;
    logic [15:0] w_index;
    logic [15:0] w_length;
  } setup_pkt_t;

  typedef struct packed {
    logic       grant;
    logic       data_avail;
    logic       setup;
    logic [7:0] data;
    logic       acked;
  } out_ep_in_t;

  typedef struct packed {
    logic grant;
    logic data_free;
    logic acked;
  } in_ep_in_t;

  typedef struct packed {
    logic       req;
    logic       data_put;
    logic [7:0] data;
    logic       data_done;
    logic       stall;
  } in_ep_out_t;

  typedef struct packed {
    rom_src_t    src;
    logic [7:0]  start_addr;
    logic [15:0] rom_len;
    logic        stall;
  } req_info_t;

  //////////////////////////////////////////////////////////////////////
  // request keys are {type bit 5, bRequest}
  //////////////////////////////////////////////////////////////////////
  localparam logic [8:0] REQ_GET_DESCRIPTOR = 9'h006;
  localparam logic [8:0] REQ_SET_ADDRESS    = 9'h005;
  localparam logic [8:0] REQ_SET_CONFIG     = 9'h009;
  localparam logic [8:0] REQ_SET_INTERFACE  = 9'h00b;
  localparam logic [8:0] REQ_DFU_DETACH     = 9'h100;
  localparam logic [8:0] REQ_DFU_GETSTATUS  = 9'h103;
  localparam logic [8:0] REQ_DFU_CLRSTATUS  = 9'h104;
  localparam logic [8:0] REQ_DFU_GETSTATE   = 9'h105;
  localparam logic [8:0] REQ_DFU_ABORT      = 9'h106;

  localparam logic [7:0] DESC_DEVICE    = 8'h01;
  localparam logic [7:0] DESC_CONFIG    = 8'h02;
  localparam logic [7:0] DESC_QUALIFIER = 8'h06;

  localparam logic [7:0] DFU_STATE_APP_IDLE   = 8'h00;
  localparam logic [7:0] DFU_STATE_APP_DETACH = 8'h01;
  localparam logic [7:0] DFU_STATUS_OK        = 8'h00;

  // descriptor rom layout
  localparam logic [7:0]  DEV_DESC_ADDR   = 8'd0;
  localparam logic [7:0]  CONF_DESC_ADDR  = 8'd18;
  localparam logic [15:0] DEV_DESC_LEN    = 16'd18;
  localparam logic [15:0] CONF_TOTAL_LEN  = 16'd27;
  localparam logic [7:0]  DFU_BSTATE_ADDR = 8'd4;   // bState within status block
  localparam logic [15:0] DFU_STATUS_LEN  = 16'd6;

  // board values
  localparam logic [7:0]  MAX_PACKET_SIZE    = 8'd32;
  localparam logic [15:0] BOARD_VID          = 16'h1234;
  localparam logic [15:0] BOARD_PID          = 16'h5678;
  localparam logic [15:0] TRANSFER_SIZE      = 16'd256;
  localparam logic [15:0] DFU_DETACH_TIMEOUT = 16'd1000;  // ms, reported only

  // detach timer, shortened for simulation
  localparam int SIM_DETACH_MS = 4;
  localparam int CYCLES_PER_MS = 16;

endpackage

// ==== hdl/usb_dfu_rt_top.sv ====
`timescale 1ns/1ps

module usb_dfu_rt_top
  import usb_dfu_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       usb_reset,
  input  out_ep_in_t out_ep,
  input  in_ep_in_t  in_ep_i,
  output logic       out_ep_req,
  output logic       out_ep_data_get,
  output in_ep_out_t in_ep_o,
  output logic [6:0] dev_addr,
  output logic       dfu_detach,
  output logic [7:0] dfu_state
);

  setup_pkt_t setup;
  req_info_t  req;
  in_ep_out_t in_ctrl;
  logic       setup_stage_end;
  logic       status_stage_end;
  logic [7:0] rom_addr;
  logic [7:0] rom_data;
  logic [7:0] dfu_status;

  setup_capture u_capture (
    .clk              (clk),
    .reset            (reset),
    .usb_reset        (usb_reset),
    .out_ep           (out_ep),
    .status_stage_end (status_stage_end),
    .setup            (setup)
  );

  ctrl_xfer_fsm u_fsm (
    .clk              (clk),
    .reset            (reset),
    .out_ep           (out_ep),
    .in_ep_i          (in_ep_i),
    .setup            (setup),
    .req              (req),
    .setup_stage_end  (setup_stage_end),
    .status_stage_end (status_stage_end),
    .rom_addr         (rom_addr),
    .out_ep_req       (out_ep_req),
    .out_ep_data_get  (out_ep_data_get),
    .in_ctrl          (in_ctrl)
  );

  dfu_request_decoder u_decoder (
    .clk              (clk),
    .reset            (reset),
    .usb_reset        (usb_reset),
    .setup            (setup),
    .setup_stage_end  (setup_stage_end),
    .status_stage_end (status_stage_end),
    .req              (req),
    .dev_addr         (dev_addr),
    .dfu_state        (dfu_state),
    .dfu_status       (dfu_status)
  );

  descriptor_rom u_rom (
    .src        (req.src),
    .rom_addr   (rom_addr),
    .dfu_state  (dfu_state),
    .dfu_status (dfu_status),
    .data       (rom_data)
  );

  dfu_detach_timer u_timer (
    .clk        (clk),
    .reset      (reset),
    .usb_reset  (usb_reset),
    .dfu_state  (dfu_state),
    .dfu_detach (dfu_detach)
  );

  // strobes from the fsm, payload from the rom
  always_comb begin
    in_ep_o      = in_ctrl;
    in_ep_o.data = rom_data;
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f all.f \
  --top-module tb_usb_dfu_rt -o sim_usb_dfu_rt
./obj_dir/sim_usb_dfu_rt | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
  exit 0
fi
exit 1

// ==== tb/dfu_checker.sv ====
`timescale 1ns/1ps

module dfu_checker
  import usb_dfu_pkg::*;
(
  input  logic        clk,
  input  in_ep_in_t   in_ep_i,
  input  in_ep_out_t  in_ep_o,
  input  logic        out_ep_req,
  input  logic        out_ep_data_get,
  input  logic [6:0]  dev_addr,
  input  logic [7:0]  dfu_state,
  input  logic        dfu_detach,
  input  logic        test_start,   // clears the records
  input  logic        test_check,   // compare now
  input  int          test_num,
  input  logic [55:0] expected,
  output int          pass_count,
  output int          fail_count
);

  typedef struct packed {
    logic [7:0] count;
    logic [7:0] first;
    logic [7:0] last;
    logic [7:0] stall;
    logic [7:0] state;
    logic [7:0] addr;
    logic [7:0] detach;
  } expect_t;

  expect_t    want;
  logic [7:0] in_count;
  logic [7:0] first_byte;
  logic [7:0] last_byte;
  logic [7:0] req_cycles;      // cycles with in_ep_o.req high
  logic [7:0] out_req_cycles;
  logic [7:0] out_get_cycles;
  logic       stall_seen;
  logic       ack_seen;
  logic [6:0] addr_at_start;
  logic [6:0] addr_at_ack;     // address while the status stage is still open
  int         errors;
  int         passed = 0;
  int         failed = 0;

  assign want       = expected;
  assign pass_count = passed;
  assign fail_count = failed;

  task automatic check_value(input string name, input logic [7:0] got,
                             input logic [7:0] exp_value);
    if (got !== exp_value) begin
      $display("Error: test %0d %s expected %h got %h", test_num, name, exp_value, got);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // record what the DUT sends during one test
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (test_start) begin
      in_count       <= 8'd0;
      first_byte     <= 8'h00;
      last_byte      <= 8'h00;
      req_cycles     <= 8'd0;
      out_req_cycles <= 8'd0;
      out_get_cycles <= 8'd0;
      stall_seen     <= 1'b0;
      ack_seen       <= 1'b0;
      addr_at_start  <= dev_addr;
    end else begin
      if (in_ep_o.data_put && in_ep_i.grant) begin  // one IN byte moved
        if (in_count == 8'd0) first_byte <= in_ep_o.data;
        last_byte <= in_ep_o.data;
        in_count  <= in_count + 8'd1;
      end
      if (in_ep_o.req) req_cycles <= req_cycles + 8'd1;
      if (out_ep_req) out_req_cycles <= out_req_cycles + 8'd1;
      if (out_ep_data_get) out_get_cycles <= out_get_cycles + 8'd1;
      if (in_ep_o.stall) stall_seen <= 1'b1;
      if (in_ep_i.acked && !ack_seen) begin
        ack_seen    <= 1'b1;
        addr_at_ack <= dev_addr;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // compare at the end of a test
  //////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (test_check) begin
      errors = 0;
      check_value("in byte count", in_count, want.count);
      if (want.count != 8'd0) begin
        check_value("first in_ep_o.data", first_byte, want.first);
        check_value("last in_ep_o.data", last_byte, want.last);
      end
      // data_free stays high, so a request lasts one cycle per byte
      check_value("in_ep_o.req cycles", req_cycles, want.count);
      // one data_avail cycle per setup byte
      check_value("out_ep_req cycles", out_req_cycles, 8'd8);
      check_value("out_ep_data_get cycles", out_get_cycles, 8'd8);
      check_value("in_ep_o.stall", {7'd0, stall_seen}, want.stall);
      if (ack_seen) begin
        check_value("dev_addr before status ack", {1'b0, addr_at_ack},
                    {1'b0, addr_at_start});
      end
      check_value("dfu_state", dfu_state, want.state);
      check_value("dev_addr", {1'b0, dev_addr}, want.addr);
      check_value("dfu_detach", {7'd0, dfu_detach}, want.detach);
      if (errors == 0) begin
        passed++;
        $display("test %0d passed, %0d in bytes", test_num, in_count);
      end else begin
        failed++;
        $display("test %0d failed with %0d errors", test_num, errors);
      end
    end
  end

endmodule

// ==== tb/dfu_tests.mem ====
// setup b0..b7 (16) | ctrl: 1 usb reset after, 2 reset before (2) | wait cycles (2)
// expected: in count, first, last, stall, dfu_state, dev_addr, dfu_detach (2 each)
8006000100004000000012120100000000 // device descriptor, w_length 64
8006000100000800000008122000000000 // device descriptor, w_length 8
800600020000ff0000001b090100000000 // configuration block, 27 bytes
8006000200000900000009093200000000 // configuration header only
8006000600000a00000000000001000000 // device qualifier stalls
800601030904ff00000000000000000000 // string, zero-length data
00052a0000000000000000000000002a00 // set address 0x2a
0009010000000000000000000000002a00 // set configuration 1
a103000000000600000006000000002a00 // getstatus in appIDLE
a105000000000100000001000000002a00 // getstate in appIDLE
010b000000000000010000000000000000 // set interface, then usb reset
2100e80300000000000000000000010000 // detach
a105000000000100000001010100010000 // getstate in appDETACH
2106000000000000000000000000000000 // abort
2100e80300000000006000000000010001 // detach, timer runs out
2100e80300000000030000000000010001 // reset, detach, usb reset
2104000000000000000000000000000001 // clrstatus, detach stays high
a103000000000600020006000000000000 // reset, getstatus

// ==== tb/tb_usb_dfu_rt.sv ====
`timescale 1ns/1ps

module tb_usb_dfu_rt;
  import usb_dfu_pkg::*;

  localparam int MAX_TESTS = 64;

  typedef struct packed {
    logic [63:0] setup_bytes;  // wire order, byte 0 in the top bits
    logic [7:0]  ctrl;         // bit 0 usb reset after, bit 1 DUT reset before
    logic [7:0]  wait_cycles;  // idle time before the check
    logic [55:0] want;
  } test_line_t;

  logic       clk = 1'b0;
  logic       reset;
  logic       usb_reset;
  out_ep_in_t out_ep;
  in_ep_in_t  in_ep_i;
  logic       out_ep_req;
  logic       out_ep_data_get;
  in_ep_out_t in_ep_o;
  logic [6:0] dev_addr;
  logic       dfu_detach;
  logic [7:0] dfu_state;

  logic        test_start;
  logic        test_check;
  int          test_num;
  logic [55:0] expected;
  int          pass_count;
  int          fail_count;

  logic [$bits(test_line_t)-1:0] tests [MAX_TESTS];
  int num_tests;
  int cycles = 0;
  int cycle_limit = 0;  // zero until the test file is read

  always #2 clk = ~clk;

  usb_dfu_rt_top UUT (
    .clk             (clk),
    .reset           (reset),
    .usb_reset       (usb_reset),
    .out_ep          (out_ep),
    .in_ep_i         (in_ep_i),
    .out_ep_req      (out_ep_req),
    .out_ep_data_get (out_ep_data_get),
    .in_ep_o         (in_ep_o),
    .dev_addr        (dev_addr),
    .dfu_detach      (dfu_detach),
    .dfu_state       (dfu_state)
  );

  dfu_checker u_checker (
    .clk             (clk),
    .in_ep_i         (in_ep_i),
    .in_ep_o         (in_ep_o),
    .out_ep_req      (out_ep_req),
    .out_ep_data_get (out_ep_data_get),
    .dev_addr        (dev_addr),
    .dfu_state       (dfu_state),
    .dfu_detach      (dfu_detach),
    .test_start      (test_start),
    .test_check      (test_check),
    .test_num        (test_num),
    .expected        (expected),
    .pass_count      (pass_count),
    .fail_count      (fail_count)
  );

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout, the tests did not finish within %0d cycles", cycle_limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // host endpoint model
  //////////////////////////////////////////////////////////////////////
  task automatic apply_reset;
    reset = 1'b1;
    repeat (4) @(negedge clk);
    reset = 1'b0;
  endtask

  // byte i is on the bus one cycle after its data_avail cycle
  task automatic send_setup(input logic [63:0] setup_bytes);
    @(negedge clk);
    out_ep.setup      = 1'b1;
    out_ep.grant      = 1'b1;
    out_ep.data_avail = 1'b1;
    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      out_ep.data = setup_bytes[63 - 8 * i -: 8];
      if (i == 7) out_ep.data_avail = 1'b0;
    end
    @(negedge clk);
    out_ep.setup = 1'b0;
    out_ep.grant = 1'b0;
  endtask

  task automatic wait_response(output logic stalled);
    while (!in_ep_o.data_done && !in_ep_o.stall) @(negedge clk);
    stalled = in_ep_o.stall;
  endtask

  task automatic finish_transfer(input logic in_data);
    @(negedge clk);
    in_ep_i.acked = 1'b1;  // ends the IN data stage, or a no-data status stage
    @(negedge clk);
    in_ep_i.acked = 1'b0;
    if (in_data) begin
      out_ep.acked = 1'b1;  // zero-length OUT status
      @(negedge clk);
      out_ep.acked = 1'b0;
    end
  endtask

  task automatic run_test(input int idx);
    test_line_t line;
    logic       stalled;
    logic       in_data;
    line    = tests[idx];
    in_data = line.setup_bytes[63] && (line.setup_bytes[15:0] != 16'h0000);
    if (line.ctrl[1]) apply_reset();
    @(negedge clk);
    test_num   = idx;
    expected   = line.want;
    test_start = 1'b1;
    @(negedge clk);
    test_start = 1'b0;
    send_setup(line.setup_bytes);
    wait_response(stalled);
    if (!stalled) finish_transfer(in_data);
    if (line.ctrl[0]) begin
      @(negedge clk);
      usb_reset = 1'b1;
      @(negedge clk);
      usb_reset = 1'b0;
    end
    repeat (int'(line.wait_cycles) + 2) @(negedge clk);
    test_check = 1'b1;
    @(negedge clk);
    test_check = 1'b0;
  endtask

  initial begin
    reset      = 1'b1;
    usb_reset  = 1'b0;
    out_ep     = '0;
    in_ep_i    = '0;
    test_start = 1'b0;
    test_check = 1'b0;
    test_num   = 0;
    expected   = '0;
    for (int i = 0; i < MAX_TESTS; i++) tests[i] = '1;  // all ones marks no test
    $readmemh("tb/dfu_tests.mem", tests);
    num_tests = 0;
    while (num_tests < MAX_TESTS && tests[num_tests] !== '1) num_tests++;
    cycle_limit = num_tests * 150 + SIM_DETACH_MS * CYCLES_PER_MS * 2;

    repeat (4) @(negedge clk);
    reset             = 1'b0;
    in_ep_i.grant     = 1'b1;
    in_ep_i.data_free = 1'b1;

    for (int t = 0; t < num_tests; t++) run_test(t);
    repeat (2) @(negedge clk);

    $display("tests run %0d, passed %0d, failed %0d", num_tests, pass_count, fail_count);
    if (num_tests > 0 && fail_count == 0 && pass_count == num_tests) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
